// ==== tb.f ====
hw/rvviTracePkg.sv
hw/rvviCsrPkg.sv
hw/rvviControl.sv
hw/csrMerge.sv
hw/gprShadow.sv
hw/retireRecord.sv
hw/rvviTracer.sv
sim/rvviTracer_properties.sv
sim/rvviTracerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -sv -j 0
TOP       ?= rvviTracerTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/rvviTracerTb.sv ====
// Directed testbench for the retirement tracer with reference shadow, watchdog and summary
`timescale 1ns/100ps

module rvviTracerTb;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 8;
  localparam int SEED = 86078;
  // Machine mode in mstatus.MPP, distinct from zero so the parameter path shows
  localparam logic [31:0] CsrInit = 32'h0000_1800;
  localparam int GPR_COUNT = 40;
  localparam int CSR_COUNT = 40;
  // Resets, random runs and short directed cases plus spare cycles
  localparam int TOTAL_CYCLES = 3 * RESET_CYCLES + GPR_COUNT + CSR_COUNT + 40;
  localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD + 400;

  // Tracked machine CSR address of each shadow slot
  localparam logic [11:0] CSR_TABLE [8] = '{
    12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h344
  };

  // DUT inputs
  logic                   rvvi;
  logic                   reset;
  logic                   retValid;
  logic [63:0]            retOrder;
  logic [31:0]            retInsn;
  logic [31:0]            retPc;
  logic                   retTrap;
  logic                   retIntr;
  rvviTracePkg::privMode  retMode;
  rvviTracePkg::trapCause retCause;
  logic [4:0]             rdAddr;
  logic [31:0]            rdWdata;
  logic                   csrValid;
  logic [11:0]            csrAddr;
  logic [31:0]            csrRdata;
  logic [31:0]            csrWdata;
  logic [31:0]            csrWmask;

  // DUT outputs
  logic                   stepValid;
  logic                   orderError;
  logic [63:0]            outOrder;
  logic [31:0]            outPc;
  logic [31:0]            outInsn;
  rvviTracePkg::privMode  outMode;
  logic                   outTrap;
  logic                   outIntr;
  logic [31:0]            xData [32];
  logic [31:0]            xWb;
  logic [31:0]            csrData [8];
  logic [7:0]             csrWb;

  // Next record as set by the tests and driven on the clock edge
  logic [63:0]            dOrder;
  logic [31:0]            dInsn;
  logic [31:0]            dPc;
  logic                   dTrap;
  logic                   dIntr;
  rvviTracePkg::privMode  dMode;
  logic [31:0]            dCause;
  logic [4:0]             dRd;
  logic [31:0]            dRdData;
  logic                   dCsrValid;
  logic [11:0]            dCsrAddr;
  logic [31:0]            dCsrRdata;
  logic [31:0]            dCsrWdata;
  logic [31:0]            dCsrWmask;

  // Reference shadow and expected outputs of the record in flight
  logic [31:0]            refX [32];
  logic [31:0]            refCsr [8];
  logic [63:0]            refNextOrder;
  logic                   refOrderErr;
  logic                   expStep;
  logic [31:0]            expXWb;
  logic [7:0]             expCsrWb;
  logic [63:0]            expOrder;
  logic [31:0]            expPc;
  logic [31:0]            expInsn;
  rvviTracePkg::privMode  expMode;
  logic                   expTrap;
  logic                   expIntr;
  // Payload fields are unknown until the first retirement
  logic                   fieldsKnown;
  int                     errors;

  rvviTracer #(
    .CsrResetValue (CsrInit)
  ) rvviTracer_inst (
    .rvvi       (rvvi),
    .reset      (reset),
    .retValid   (retValid),
    .retOrder   (retOrder),
    .retInsn    (retInsn),
    .retPc      (retPc),
    .retTrap    (retTrap),
    .retIntr    (retIntr),
    .retMode    (retMode),
    .retCause   (retCause),
    .rdAddr     (rdAddr),
    .rdWdata    (rdWdata),
    .csrValid   (csrValid),
    .csrAddr    (csrAddr),
    .csrRdata   (csrRdata),
    .csrWdata   (csrWdata),
    .csrWmask   (csrWmask),
    .stepValid  (stepValid),
    .orderError (orderError),
    .outOrder   (outOrder),
    .outPc      (outPc),
    .outInsn    (outInsn),
    .outMode    (outMode),
    .outTrap    (outTrap),
    .outIntr    (outIntr),
    .xData      (xData),
    .xWb        (xWb),
    .csrData    (csrData),
    .csrWb      (csrWb)
  );

  initial begin
    rvvi = 1'b0;
    forever #(CLK_PERIOD / 2) rvvi = ~rvvi;
  end

  //////////////////////////////
  // Checking and reference model
  //////////////////////////////

  task automatic checkEq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Outputs against the record driven one cycle earlier
  task automatic checkOutputs();
    checkEq("stepValid", 64'(stepValid), 64'(expStep));
    checkEq("orderError", 64'(orderError), 64'(refOrderErr));
    checkEq("xWb", 64'(xWb), 64'(expXWb));
    checkEq("csrWb", 64'(csrWb), 64'(expCsrWb));
    for (int i = 0; i < 32; i++) begin
      checkEq($sformatf("xData[%0d]", i), 64'(xData[i]), 64'(refX[i]));
    end
    for (int s = 0; s < 8; s++) begin
      checkEq($sformatf("csrData[%0d]", s), 64'(csrData[s]), 64'(refCsr[s]));
    end
    if (fieldsKnown) begin
      checkEq("outOrder", outOrder, expOrder);
      checkEq("outPc", 64'(outPc), 64'(expPc));
      checkEq("outInsn", 64'(outInsn), 64'(expInsn));
      checkEq("outMode", 64'(outMode), 64'(expMode));
      checkEq("outTrap", 64'(outTrap), 64'(expTrap));
      checkEq("outIntr", 64'(outIntr), 64'(expIntr));
    end
  endtask

  // Expected view after the record now on the inputs
  task automatic predictRecord(input bit valid);
    logic [31:0] merged;
    expStep = 1'b0;
    expXWb = '0;
    expCsrWb = '0;
    if (valid) begin
      fieldsKnown = 1'b1;
      expOrder = dOrder;
      expPc = dPc;
      expInsn = dInsn;
      expMode = dMode;
      expTrap = dTrap;
      expIntr = dIntr;
      // Exception with code 1 is an instruction fetch fault and never steps
      expStep = !(dTrap && !dCause[31] && (dCause[30:0] == 31'd1));
      if (dOrder != refNextOrder) begin
        refOrderErr = 1'b1;
      end
      refNextOrder = dOrder + 64'd1;
      if (dRd != 5'd0) begin
        refX[dRd] = dRdData;
        expXWb[dRd] = 1'b1;
      end
      // Masked bits take wdata and all others keep rdata
      for (int b = 0; b < 32; b++) begin
        merged[b] = dCsrWmask[b] ? dCsrWdata[b] : dCsrRdata[b];
      end
      for (int s = 0; s < 8; s++) begin
        if (dCsrValid && dCsrAddr == CSR_TABLE[s] && merged != refCsr[s]) begin
          refCsr[s] = merged;
          expCsrWb[s] = 1'b1;
        end
      end
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic applyReset();
    @(posedge rvvi);
    reset <= 1'b1;
    retValid <= 1'b0;
    repeat (RESET_CYCLES) @(posedge rvvi);
    reset <= 1'b0;
    for (int i = 0; i < 32; i++) begin
      refX[i] = '0;
    end
    for (int s = 0; s < 8; s++) begin
      refCsr[s] = CsrInit;
    end
    refNextOrder = '0;
    refOrderErr = 1'b0;
    expStep = 1'b0;
    expXWb = '0;
    expCsrWb = '0;
    fieldsKnown = 1'b0;
    dOrder = '0;
  endtask

  // One clock that drives a record or idles and checks the previous one
  task automatic runCycle(input bit valid);
    @(posedge rvvi);
    retValid <= valid;
    retOrder <= dOrder;
    retInsn <= dInsn;
    retPc <= dPc;
    retTrap <= dTrap;
    retIntr <= dIntr;
    retMode <= dMode;
    retCause <= dCause;
    rdAddr <= dRd;
    rdWdata <= dRdData;
    csrValid <= dCsrValid;
    csrAddr <= dCsrAddr;
    csrRdata <= dCsrRdata;
    csrWdata <= dCsrWdata;
    csrWmask <= dCsrWmask;
    @(negedge rvvi);
    checkOutputs();
    predictRecord(valid);
    if (valid) begin
      dOrder = dOrder + 64'd1;
    end
  endtask

  // Plain non-trapping record with random pc and instruction
  task automatic randomRecord();
    dPc = $urandom() & 32'hFFFF_FFFC;
    dInsn = $urandom();
    dTrap = 1'b0;
    dIntr = 1'b0;
    dMode = ($urandom_range(0, 1) == 0) ? rvviTracePkg::PRIV_MACHINE : rvviTracePkg::PRIV_USER;
    dCause = '0;
    dRd = '0;
    dRdData = '0;
    dCsrValid = 1'b0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic resetStateTest();
    applyReset();
    runCycle(1'b0);
    runCycle(1'b0);
  endtask

  task automatic gprWriteTest();
    for (int i = 0; i < GPR_COUNT; i++) begin
      randomRecord();
      dRd = 5'($urandom_range(0, 31));
      dRdData = $urandom();
      // Regular x0 writes mixed in
      if (i % 8 == 0) begin
        dRd = 5'd0;
      end
      runCycle(1'b1);
    end
    runCycle(1'b0);
  endtask

  task automatic csrMergeTest();
    int slot;
    for (int i = 0; i < CSR_COUNT; i++) begin
      randomRecord();
      slot = $urandom_range(0, 7);
      dCsrValid = 1'b1;
      dCsrAddr = CSR_TABLE[slot];
      dCsrRdata = $urandom();
      dCsrWdata = $urandom();
      dCsrWmask = $urandom();
      // Rewrite of the shadowed value leaves csrWb low
      if (i % 4 == 3) begin
        dCsrWmask = '1;
        dCsrWdata = refCsr[slot];
      end
      runCycle(1'b1);
    end
    // mtval and a custom CSR are not tracked
    randomRecord();
    dCsrValid = 1'b1;
    dCsrAddr = 12'h343;
    dCsrWmask = '1;
    dCsrWdata = 32'hDEAD_BEEF;
    runCycle(1'b1);
    dCsrAddr = 12'h7C0;
    runCycle(1'b1);
    runCycle(1'b0);
  endtask

  task automatic fetchFaultTest();
    // Instruction access fault passes its fields without a step
    randomRecord();
    dTrap = 1'b1;
    dCause = 32'h0000_0001;
    runCycle(1'b1);
    // Interrupt with the same code steps
    randomRecord();
    dTrap = 1'b1;
    dIntr = 1'b1;
    dCause = 32'h8000_0001;
    runCycle(1'b1);
    // Illegal instruction steps
    randomRecord();
    dTrap = 1'b1;
    dCause = 32'h0000_0002;
    runCycle(1'b1);
    runCycle(1'b0);
  endtask

  task automatic orderContinuityTest();
    repeat (4) begin
      randomRecord();
      runCycle(1'b1);
    end
    // One order number skipped
    randomRecord();
    dOrder = dOrder + 64'd1;
    runCycle(1'b1);
    repeat (4) begin
      randomRecord();
      runCycle(1'b1);
    end
    runCycle(1'b0);
    checkEq("orderError after gap", 64'(orderError), 64'd1);
    // Only reset clears the flag
    applyReset();
    runCycle(1'b0);
  endtask

  initial begin
    reset = 1'b1;
    retValid = 1'b0;
    retOrder = '0;
    retInsn = '0;
    retPc = '0;
    retTrap = 1'b0;
    retIntr = 1'b0;
    retMode = rvviTracePkg::PRIV_MACHINE;
    retCause = '0;
    rdAddr = '0;
    rdWdata = '0;
    csrValid = 1'b0;
    csrAddr = '0;
    csrRdata = '0;
    csrWdata = '0;
    csrWmask = '0;
    errors = 0;
    void'($urandom(SEED));
    randomRecord();
    resetStateTest();
    gprWriteTest();
    csrMergeTest();
    fetchFaultTest();
    orderContinuityTest();
    // Bound property failures count as errors too
    errors += rvviTracer_inst.rvviTracerProps_inst.failures;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the test lengths
  initial begin
    #(WATCHDOG_NS);
    errors += rvviTracer_inst.rvviTracerProps_inst.failures;
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Errors: %0d", errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== sim/rvviTracer_properties.sv ====
// Bound concurrent checks on tracer write-back masks, CSR change flags and step strobe
`timescale 1ns/100ps

module rvviTracerProps (
  input logic                                 rvvi,
  input logic                                 reset,
  input logic                                 retValid,
  input logic                                 stepValid,
  input logic [rvviTracePkg::NUM_XREG-1:0]    xWb,
  input logic [rvviCsrPkg::NUM_TRACKED-1:0]   csrWb
);

  // Failed property count for the testbench verdict
  int failures = 0;

  // At most one register written per retirement and never x0
  xWbShape: assert property (@(posedge rvvi) disable iff (reset)
    $onehot0(xWb) && !xWb[0])
    else begin
      failures++;
      $error("xWb is neither zero nor one-hot, or it flags x0");
    end

  // CSR change flags only follow an accepted retirement
  csrWbAfterValid: assert property (@(posedge rvvi) disable iff (reset)
    (csrWb != '0) |-> $past(retValid))
    else begin
      failures++;
      $error("csrWb raised in a cycle after no retirement");
    end

  // Step strobe is the registered retirement strobe
  stepAfterValid: assert property (@(posedge rvvi) disable iff (reset)
    stepValid |-> $past(retValid))
    else begin
      failures++;
      $error("stepValid high without a retirement the cycle before");
    end

endmodule

// Attached to every tracer instance
bind rvviTracer rvviTracerProps rvviTracerProps_inst (
  .rvvi      (rvvi),
  .reset     (reset),
  .retValid  (retValid),
  .stepValid (stepValid),
  .xWb       (xWb),
  .csrWb     (csrWb)
);

// ==== hw/rvviTracer.sv ====
// Retirement tracer top level joining control, CSR merge, register shadow and record stage
`timescale 1ns/100ps

module rvviTracer #(
  parameter logic [rvviTracePkg::XLEN-1:0] CsrResetValue = '0
) (
  input  logic                                  rvvi,
  input  logic                                  reset,
  // Retirement record
  input  logic                                  retValid,
  input  logic [rvviTracePkg::ORDER_W-1:0]      retOrder,
  input  logic [rvviTracePkg::XLEN-1:0]         retInsn,
  input  logic [rvviTracePkg::XLEN-1:0]         retPc,
  input  logic                                  retTrap,
  input  logic                                  retIntr,
  input  rvviTracePkg::privMode                 retMode,
  input  rvviTracePkg::trapCause                retCause,
  // Destination register write
  input  logic [rvviTracePkg::REG_ADDR_W-1:0]   rdAddr,
  input  logic [rvviTracePkg::XLEN-1:0]         rdWdata,
  // CSR access
  input  logic                                  csrValid,
  input  logic [rvviCsrPkg::CSR_ADDR_W-1:0]     csrAddr,
  input  logic [rvviTracePkg::XLEN-1:0]         csrRdata,
  input  logic [rvviTracePkg::XLEN-1:0]         csrWdata,
  input  logic [rvviTracePkg::XLEN-1:0]         csrWmask,
  // Registered architectural view
  output logic                                  stepValid,
  output logic                                  orderError,
  output logic [rvviTracePkg::ORDER_W-1:0]      outOrder,
  output logic [rvviTracePkg::XLEN-1:0]         outPc,
  output logic [rvviTracePkg::XLEN-1:0]         outInsn,
  output rvviTracePkg::privMode                 outMode,
  output logic                                  outTrap,
  output logic                                  outIntr,
  output logic [rvviTracePkg::XLEN-1:0]         xData [rvviTracePkg::NUM_XREG],
  output logic [rvviTracePkg::NUM_XREG-1:0]     xWb,
  output logic [rvviTracePkg::XLEN-1:0]         csrData [rvviCsrPkg::NUM_TRACKED],
  output logic [rvviCsrPkg::NUM_TRACKED-1:0]    csrWb
);

  // Common load pulse for all register stages
  logic stageEnable;

  //////////////////////////////
  // Control
  //////////////////////////////
  rvviControl rvviControl_inst (
    .rvvi        (rvvi),
    .reset       (reset),
    .retValid    (retValid),
    .retOrder    (retOrder),
    .retTrap     (retTrap),
    .retCause    (retCause),
    .stageEnable (stageEnable),
    .stepValid   (stepValid),
    .orderError  (orderError)
  );

  //////////////////////////////
  // Datapath stages
  //////////////////////////////

  // CSR shadow, reset value must match the core's
  csrMerge #(
    .CsrResetValue (CsrResetValue)
  ) csrMerge_inst (
    .rvvi        (rvvi),
    .reset       (reset),
    .stageEnable (stageEnable),
    .csrValid    (csrValid),
    .csrAddr     (csrAddr),
    .csrRdata    (csrRdata),
    .csrWdata    (csrWdata),
    .csrWmask    (csrWmask),
    .csrData     (csrData),
    .csrWb       (csrWb)
  );

  // Single destination register per retirement
  gprShadow gprShadow_inst (
    .rvvi        (rvvi),
    .reset       (reset),
    .stageEnable (stageEnable),
    .rdAddr      (rdAddr),
    .rdWdata     (rdWdata),
    .xData       (xData),
    .xWb         (xWb)
  );

  retireRecord retireRecord_inst (
    .rvvi        (rvvi),
    .reset       (reset),
    .stageEnable (stageEnable),
    .retOrder    (retOrder),
    .retPc       (retPc),
    .retInsn     (retInsn),
    .retMode     (retMode),
    .retTrap     (retTrap),
    .retIntr     (retIntr),
    .outOrder    (outOrder),
    .outPc       (outPc),
    .outInsn     (outInsn),
    .outMode     (outMode),
    .outTrap     (outTrap),
    .outIntr     (outIntr)
  );

endmodule

// ==== hw/retireRecord.sv ====
// Output register for order, pc, instruction, mode and trap fields of a retirement
`timescale 1ns/100ps

module retireRecord (
  input  logic                                rvvi,
  input  logic                                reset,
  input  logic                                stageEnable,
  input  logic [rvviTracePkg::ORDER_W-1:0]    retOrder,
  input  logic [rvviTracePkg::XLEN-1:0]       retPc,
  input  logic [rvviTracePkg::XLEN-1:0]       retInsn,
  input  rvviTracePkg::privMode               retMode,
  input  logic                                retTrap,
  input  logic                                retIntr,
  output logic [rvviTracePkg::ORDER_W-1:0]    outOrder,
  output logic [rvviTracePkg::XLEN-1:0]       outPc,
  output logic [rvviTracePkg::XLEN-1:0]       outInsn,
  output rvviTracePkg::privMode               outMode,
  output logic                                outTrap,
  output logic                                outIntr
);

  // Status flags and mode, cleared to a core's reset state
  always_ff @(posedge rvvi) begin
    if (reset) begin
      outMode <= rvviTracePkg::PRIV_MACHINE;
      outTrap <= 1'b0;
      outIntr <= 1'b0;
    end else if (stageEnable) begin
      outMode <= retMode;
      outTrap <= retTrap;
      outIntr <= retIntr;
    end
  end

  // Payload words, held between retirements
  // Same stage as stepValid so the model sees one aligned record
  always_ff @(posedge rvvi) begin
    if (stageEnable) begin
      outOrder <= retOrder;
      outPc    <= retPc;
      outInsn  <= retInsn;
    end
  end

endmodule

// ==== hw/gprShadow.sv ====
// Integer register shadow with x0 suppression and one-hot write-back mask
`timescale 1ns/100ps

module gprShadow (
  input  logic                                  rvvi,
  input  logic                                  reset,
  input  logic                                  stageEnable,
  input  logic [rvviTracePkg::REG_ADDR_W-1:0]   rdAddr,
  input  logic [rvviTracePkg::XLEN-1:0]         rdWdata,
  output logic [rvviTracePkg::XLEN-1:0]         xData [rvviTracePkg::NUM_XREG],
  output logic [rvviTracePkg::NUM_XREG-1:0]     xWb
);

  // Write qualifier and decoded destination
  logic                                 writeEnable;
  logic [rvviTracePkg::NUM_XREG-1:0]    rdOneHot;

  // x0 is hardwired, a write to it is no write
  assign writeEnable = stageEnable && (rdAddr != '0);

  // Destination as a one-hot bit
  assign rdOneHot = rvviTracePkg::NUM_XREG'(1) << rdAddr;

  //////////////////////////////
  // Register shadow
  //////////////////////////////

  // x0 is cleared here and never written afterwards
  always_ff @(posedge rvvi) begin
    if (reset) begin
      xWb <= '0;
      for (int i = 0; i < rvviTracePkg::NUM_XREG; i++) begin
        xData[i] <= '0;
      end
    end else begin
      // Mask drops back to zero without a write
      xWb <= '0;
      if (writeEnable) begin
        xData[rdAddr] <= rdWdata;
        xWb           <= rdOneHot;
      end
    end
  end

endmodule

// ==== hw/csrMerge.sv ====
// Masked CSR merge, tracked machine CSR shadow file and per-slot change flags
`timescale 1ns/100ps

module csrMerge #(
  parameter logic [rvviTracePkg::XLEN-1:0] CsrResetValue = '0
) (
  input  logic                                 rvvi,
  input  logic                                 reset,
  input  logic                                 stageEnable,
  input  logic                                 csrValid,
  input  logic [rvviCsrPkg::CSR_ADDR_W-1:0]    csrAddr,
  input  logic [rvviTracePkg::XLEN-1:0]        csrRdata,
  input  logic [rvviTracePkg::XLEN-1:0]        csrWdata,
  input  logic [rvviTracePkg::XLEN-1:0]        csrWmask,
  output logic [rvviTracePkg::XLEN-1:0]        csrData [rvviCsrPkg::NUM_TRACKED],
  output logic [rvviCsrPkg::NUM_TRACKED-1:0]   csrWb
);

  // Merged CSR word, the cause union so mcause lands as its raw word
  rvviTracePkg::trapCause mergedValue;

  // Slot match and value change per slot
  logic [rvviCsrPkg::NUM_TRACKED-1:0] slotHit;
  logic [rvviCsrPkg::NUM_TRACKED-1:0] slotChange;

  //////////////////////////////
  // Merge
  //////////////////////////////

  // Written bits from wdata, untouched bits from rdata
  always_comb begin
    mergedValue.raw = (csrWdata & csrWmask) | (csrRdata & ~csrWmask);
  end

  //////////////////////////////
  // Slot lookup
  //////////////////////////////

  // Table addresses are unique, so at most one slot hits
  // Untracked addresses hit nothing and are dropped
  always_comb begin
    for (int i = 0; i < rvviCsrPkg::NUM_TRACKED; i++) begin
      slotHit[i]    = csrValid && (csrAddr == rvviCsrPkg::trackedAddr[i]);
      slotChange[i] = slotHit[i] && (mergedValue.raw != csrData[i]);
    end
  end

  //////////////////////////////
  // Shadow file
  //////////////////////////////

  // Shadow starts at the reset value seen by the model
  always_ff @(posedge rvvi) begin
    if (reset) begin
      csrWb <= '0;
      for (int i = 0; i < rvviCsrPkg::NUM_TRACKED; i++) begin
        csrData[i] <= CsrResetValue;
      end
    end else begin
      // Change flags live for one cycle only
      csrWb <= stageEnable ? slotChange : '0;
      for (int i = 0; i < rvviCsrPkg::NUM_TRACKED; i++) begin
        // Rewrite of the same value leaves the flag low
        if (stageEnable && slotChange[i]) begin
          csrData[i] <= mergedValue.raw;
        end
      end
    end
  end

endmodule

// ==== hw/rvviControl.sv ====
// Retirement control with fetch-fault step blocking, order continuity check and stage enable
`timescale 1ns/100ps

module rvviControl (
  input  logic                                rvvi,
  input  logic                                reset,
  input  logic                                retValid,
  input  logic [rvviTracePkg::ORDER_W-1:0]    retOrder,
  input  logic                                retTrap,
  input  rvviTracePkg::trapCause              retCause,
  output logic                                stageEnable,
  output logic                                stepValid,
  output logic                                orderError
);

  // Decoded trap kind
  logic isException;
  logic isFetchFault;
  logic stepBlocked;

  // Order tracking
  logic [rvviTracePkg::ORDER_W-1:0] expectedOrder;
  logic                             orderMismatch;

  //////////////////////////////
  // Trap decode
  //////////////////////////////

  // Interrupt flag clear means a synchronous exception
  assign isException = !retCause.fields.intr;

  // Fetch faults come from the bus, not from the model
  assign isFetchFault = (retCause.fields.code == rvviTracePkg::FETCH_FAULT_CODE);

  // Stepping the model here would run it one instruction too far
  // Fields still flow, only the step strobe is held low
  assign stepBlocked = retTrap && isException && isFetchFault;

  // Every datapath block loads on every retirement
  assign stageEnable = retValid;

  //////////////////////////////
  // Step strobe
  //////////////////////////////

  // One cycle per accepted retirement that the model may step on
  always_ff @(posedge rvvi) begin
    if (reset) begin
      stepValid <= 1'b0;
    end else begin
      stepValid <= retValid && !stepBlocked;
    end
  end

  //////////////////////////////
  // Order continuity
  //////////////////////////////

  assign orderMismatch = (retOrder != expectedOrder);

  // Expected order follows the record, so one gap flags once
  // and later contiguous records still line up
  always_ff @(posedge rvvi) begin
    if (reset) begin
      expectedOrder <= '0;
      orderError    <= 1'b0;
    end else if (retValid) begin
      expectedOrder <= retOrder + 1'b1;
      // Sticky until reset
      if (orderMismatch) begin
        orderError <= 1'b1;
      end
    end
  end

endmodule

// ==== hw/rvviCsrPkg.sv ====
// CSR address constants, tracked-CSR slot numbers and the slot address table
package rvviCsrPkg;

  // CSR address field of the instruction
  localparam int CSR_ADDR_W = 12;

  // Number of shadowed machine CSRs
  localparam int NUM_TRACKED = 8;

  //////////////////////////////
  // Machine CSR addresses
  //////////////////////////////
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MISA     = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP      = 12'h344;

  //////////////////////////////
  // Shadow slots
  //////////////////////////////
  localparam int MSTATUS_SLOT  = 0;
  localparam int MISA_SLOT     = 1;
  localparam int MIE_SLOT      = 2;
  localparam int MTVEC_SLOT    = 3;
  localparam int MSCRATCH_SLOT = 4;
  localparam int MEPC_SLOT     = 5;
  localparam int MCAUSE_SLOT   = 6;
  localparam int MIP_SLOT      = 7;

  // Address held by each slot
  localparam logic [CSR_ADDR_W-1:0] trackedAddr [NUM_TRACKED] = '{
    MSTATUS_SLOT:  CSR_MSTATUS,
    MISA_SLOT:     CSR_MISA,
    MIE_SLOT:      CSR_MIE,
    MTVEC_SLOT:    CSR_MTVEC,
    MSCRATCH_SLOT: CSR_MSCRATCH,
    MEPC_SLOT:     CSR_MEPC,
    MCAUSE_SLOT:   CSR_MCAUSE,
    MIP_SLOT:      CSR_MIP
  };

endpackage

// ==== hw/rvviTracePkg.sv ====
// Retirement record widths, privilege modes, trap cause word and fetch fault code
package rvviTracePkg;

  //////////////////////////////
  // Record widths
  //////////////////////////////

  // One architectural word
  localparam int XLEN = 32;

  // Retirement order counter
  localparam int ORDER_W = 64;

  // Integer register file geometry
  localparam int NUM_XREG = 32;
  localparam int REG_ADDR_W = $clog2(NUM_XREG);

  //////////////////////////////
  // Privilege and trap types
  //////////////////////////////

  // Privilege mode as reported by the core, hypervisor encoding unused
  typedef enum logic [1:0] {
    PRIV_USER       = 2'b00,
    PRIV_SUPERVISOR = 2'b01,
    PRIV_MACHINE    = 2'b11
  } privMode;

  // Cause word, stored whole as mcause or split for trap decode
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      // Set for interrupts, clear for exceptions
      logic            intr;
      logic [XLEN-2:0] code;
    } fields;
  } trapCause;

  // Instruction access fault
  // The core raises it from outside the reference model's view
  localparam logic [XLEN-2:0] FETCH_FAULT_CODE = 'd1;

endpackage
